// ==== include/dmem_config.svh ====
`ifndef DMEM_CONFIG_SVH
`define DMEM_CONFIG_SVH

// Word width of both banks
`define DMEM_DATA_W 32

// Byte address width seen by each port
`define DMEM_ADDR_W 7

// Words held by one bank
`define DMEM_WORDS 16

// Address bit that picks the bank
// 0 selects the processor bank, 1 the controller bank
`define DMEM_BANK_BIT 6

`endif

// ==== hw/mem_access_pkg.sv ====
`default_nettype none

package mem_access_pkg;

	// Load operation codes, 5 to 7 read back as zero
	typedef enum logic [2:0] {
		LD_W  = 3'd0,
		LD_H  = 3'd1,
		LD_HU = 3'd2,
		LD_B  = 3'd3,
		LD_BU = 3'd4
	} load_op_t;

	// Store operation codes
	typedef enum logic [1:0] {
		ST_W    = 2'd0,
		ST_H    = 2'd1,
		ST_B    = 2'd2,
		ST_NONE = 2'd3 // No write, flagged as an error
	} store_op_t;

endpackage

`default_nettype wire

// ==== hw/mem_map_pkg.sv ====
`default_nettype none

`include "dmem_config.svh"

package mem_map_pkg;

	typedef enum logic {
		BANK_PROC = 1'b0,
		BANK_CTRL = 1'b1
	} bank_t;

	typedef logic [$clog2(`DMEM_WORDS)-1:0] word_idx_t; // Word within a bank

	typedef logic [$clog2(`DMEM_DATA_W / 8)-1:0] lane_t; // Byte lane within a word

	// One bit per byte lane, bit 0 is the low byte
	typedef logic [`DMEM_DATA_W/8-1:0] byte_en_t;

endpackage

`default_nettype wire

// ==== hw/dmem_bank.sv ====
`default_nettype none

`include "dmem_config.svh"

module dmem_bank (
	input  logic                   clk,
	input  logic                   rst,

	// Write port a, processor side
	input  logic                   a_wr,
	input  mem_map_pkg::word_idx_t a_idx,
	input  mem_map_pkg::byte_en_t  a_be,
	input  logic [`DMEM_DATA_W-1:0] a_data,

	// Write port b, controller side
	input  logic                   b_wr,
	input  mem_map_pkg::word_idx_t b_idx,
	input  mem_map_pkg::byte_en_t  b_be,
	input  logic [`DMEM_DATA_W-1:0] b_data,

	// Registered read ports
	input  mem_map_pkg::word_idx_t a_rd_idx,
	input  mem_map_pkg::word_idx_t b_rd_idx,
	output logic [`DMEM_DATA_W-1:0] a_rd_data,
	output logic [`DMEM_DATA_W-1:0] b_rd_data
);

	localparam int LANES = `DMEM_DATA_W / 8;

	logic [`DMEM_DATA_W-1:0] mem [`DMEM_WORDS];

	// Reads sample the old contents, so a same-cycle store is not seen yet
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `DMEM_WORDS; i++) begin
				mem[i] <= '0;
			end
			a_rd_data <= '0;
			b_rd_data <= '0;
		end else begin
			a_rd_data <= mem[a_rd_idx];
			b_rd_data <= mem[b_rd_idx];

			for (int l = 0; l < LANES; l++) begin
				if (a_wr && a_be[l]) begin
					mem[a_idx][8*l +: 8] <= a_data[8*l +: 8];
				end
			end

			// Port b last, so controller bytes win a collision
			for (int l = 0; l < LANES; l++) begin
				if (b_wr && b_be[l]) begin
					mem[b_idx][8*l +: 8] <= b_data[8*l +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/dmem_port.sv ====
`default_nettype none

`include "dmem_config.svh"

module dmem_port (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      req,
	input  logic                      we,
	input  logic [`DMEM_ADDR_W-1:0]   addr,
	input  logic [`DMEM_DATA_W-1:0]   wdata,
	input  mem_access_pkg::load_op_t  load_op,
	input  mem_access_pkg::store_op_t store_op,

	// Write side into both banks
	output logic                      wr_proc,
	output logic                      wr_ctrl,
	output mem_map_pkg::word_idx_t    wr_idx,
	output mem_map_pkg::byte_en_t     wr_be,
	output logic [`DMEM_DATA_W-1:0]   wr_data,

	// Read side from this port's read port of both banks
	output mem_map_pkg::word_idx_t    rd_idx,
	input  logic [`DMEM_DATA_W-1:0]   rd_word_proc,
	input  logic [`DMEM_DATA_W-1:0]   rd_word_ctrl,

	output logic [`DMEM_DATA_W-1:0]   rdata,
	output logic                      rvalid,
	output logic                      err
);

	localparam int LANE_W = $bits(mem_map_pkg::lane_t);

	mem_map_pkg::bank_t       bank;
	mem_map_pkg::word_idx_t   word_idx;
	mem_map_pkg::lane_t       lane;
	logic                     load_aligned;
	logic                     store_aligned;
	logic                     store_go;

	mem_map_pkg::bank_t       bank_q;
	mem_map_pkg::lane_t       lane_q;
	mem_access_pkg::load_op_t op_q;

	// Address split into bank, word and lane
	assign bank     = mem_map_pkg::bank_t'(addr[`DMEM_BANK_BIT]);
	assign word_idx = addr[`DMEM_BANK_BIT-1:LANE_W];
	assign lane     = addr[LANE_W-1:0];

	assign rd_idx = word_idx; // Read every cycle, only used when a load was taken
	assign wr_idx = word_idx;

	always_comb begin
		case (load_op)
			mem_access_pkg::LD_W:  load_aligned = (lane == '0);
			mem_access_pkg::LD_H,
			mem_access_pkg::LD_HU: load_aligned = ~lane[0];
			default:               load_aligned = 1'b1; // Bytes and invalid codes
		endcase
	end

	// Store lanes are replicated so the byte enables alone pick the target
	always_comb begin
		store_aligned = 1'b0;
		wr_be         = '0;
		wr_data       = wdata;
		case (store_op)
			mem_access_pkg::ST_W: begin
				store_aligned = (lane == '0);
				wr_be         = '1;
			end
			mem_access_pkg::ST_H: begin
				store_aligned = ~lane[0];
				wr_be         = lane[1] ? 4'b1100 : 4'b0011;
				wr_data       = {2{wdata[15:0]}};
			end
			mem_access_pkg::ST_B: begin
				store_aligned = 1'b1;
				wr_be         = 4'b0001 << lane;
				wr_data       = {4{wdata[7:0]}};
			end
			default: begin
				store_aligned = 1'b0; // ST_NONE never writes
			end
		endcase
	end

	assign store_go = req && we && store_aligned;
	assign wr_proc  = store_go && (bank == mem_map_pkg::BANK_PROC);
	assign wr_ctrl  = store_go && (bank == mem_map_pkg::BANK_CTRL);

	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid <= 1'b0;
			err    <= 1'b0;
		end else begin
			rvalid <= req && !we && load_aligned;
			err    <= req && (we ? !store_aligned : !load_aligned);
		end
	end

	// Load context for the extraction in the next cycle
	always_ff @(posedge clk) begin
		bank_q <= bank;
		lane_q <= lane;
		op_q   <= load_op;
	end

	always_comb begin
		logic [`DMEM_DATA_W-1:0] word;
		logic [15:0]             sel_half;
		logic [7:0]              sel_byte;

		word     = (bank_q == mem_map_pkg::BANK_CTRL) ? rd_word_ctrl : rd_word_proc;
		sel_half = lane_q[1] ? word[31:16] : word[15:0];
		sel_byte = word[8*lane_q +: 8];

		case (op_q)
			mem_access_pkg::LD_W:  rdata = word;
			mem_access_pkg::LD_H:  rdata = {{16{sel_half[15]}}, sel_half};
			mem_access_pkg::LD_HU: rdata = {16'h0, sel_half};
			mem_access_pkg::LD_B:  rdata = {{24{sel_byte[7]}}, sel_byte};
			mem_access_pkg::LD_BU: rdata = {24'h0, sel_byte};
			default:               rdata = '0;
		endcase

		if (!rvalid) begin
			rdata = '0; // Quiet bus unless a load returns
		end
	end

endmodule

`default_nettype wire

// ==== hw/shared_dmem.sv ====
`default_nettype none

`include "dmem_config.svh"

module shared_dmem (
	input  logic                      clk,
	input  logic                      rst,

	// Processor port
	input  logic                      p_req,
	input  logic                      p_we,
	input  logic [`DMEM_ADDR_W-1:0]   p_addr,
	input  logic [`DMEM_DATA_W-1:0]   p_wdata,
	input  mem_access_pkg::load_op_t  p_load_op,
	input  mem_access_pkg::store_op_t p_store_op,
	output logic [`DMEM_DATA_W-1:0]   p_rdata,
	output logic                      p_rvalid,
	output logic                      p_err,

	// Controller port
	input  logic                      c_req,
	input  logic                      c_we,
	input  logic [`DMEM_ADDR_W-1:0]   c_addr,
	input  logic [`DMEM_DATA_W-1:0]   c_wdata,
	input  mem_access_pkg::load_op_t  c_load_op,
	input  mem_access_pkg::store_op_t c_store_op,
	output logic [`DMEM_DATA_W-1:0]   c_rdata,
	output logic                      c_rvalid,
	output logic                      c_err
);

	logic                    p_wr_proc, p_wr_ctrl;
	mem_map_pkg::word_idx_t  p_wr_idx, p_rd_idx;
	mem_map_pkg::byte_en_t   p_wr_be;
	logic [`DMEM_DATA_W-1:0] p_wr_data;

	logic                    c_wr_proc, c_wr_ctrl;
	mem_map_pkg::word_idx_t  c_wr_idx, c_rd_idx;
	mem_map_pkg::byte_en_t   c_wr_be;
	logic [`DMEM_DATA_W-1:0] c_wr_data;

	// Read words, named by bank then by reading port
	logic [`DMEM_DATA_W-1:0] proc_bank_p_rd, proc_bank_c_rd;
	logic [`DMEM_DATA_W-1:0] ctrl_bank_p_rd, ctrl_bank_c_rd;

	dmem_port u_proc_port (
		.clk          (clk),
		.rst          (rst),
		.req          (p_req),
		.we           (p_we),
		.addr         (p_addr),
		.wdata        (p_wdata),
		.load_op      (p_load_op),
		.store_op     (p_store_op),
		.wr_proc      (p_wr_proc),
		.wr_ctrl      (p_wr_ctrl),
		.wr_idx       (p_wr_idx),
		.wr_be        (p_wr_be),
		.wr_data      (p_wr_data),
		.rd_idx       (p_rd_idx),
		.rd_word_proc (proc_bank_p_rd),
		.rd_word_ctrl (ctrl_bank_p_rd),
		.rdata        (p_rdata),
		.rvalid       (p_rvalid),
		.err          (p_err)
	);

	dmem_port u_ctrl_port (
		.clk          (clk),
		.rst          (rst),
		.req          (c_req),
		.we           (c_we),
		.addr         (c_addr),
		.wdata        (c_wdata),
		.load_op      (c_load_op),
		.store_op     (c_store_op),
		.wr_proc      (c_wr_proc),
		.wr_ctrl      (c_wr_ctrl),
		.wr_idx       (c_wr_idx),
		.wr_be        (c_wr_be),
		.wr_data      (c_wr_data),
		.rd_idx       (c_rd_idx),
		.rd_word_proc (proc_bank_c_rd),
		.rd_word_ctrl (ctrl_bank_c_rd),
		.rdata        (c_rdata),
		.rvalid       (c_rvalid),
		.err          (c_err)
	);

	// Processor on bank port a, controller on port b
	dmem_bank u_proc_bank (
		.clk       (clk),
		.rst       (rst),
		.a_wr      (p_wr_proc),
		.a_idx     (p_wr_idx),
		.a_be      (p_wr_be),
		.a_data    (p_wr_data),
		.b_wr      (c_wr_proc),
		.b_idx     (c_wr_idx),
		.b_be      (c_wr_be),
		.b_data    (c_wr_data),
		.a_rd_idx  (p_rd_idx),
		.b_rd_idx  (c_rd_idx),
		.a_rd_data (proc_bank_p_rd),
		.b_rd_data (proc_bank_c_rd)
	);

	dmem_bank u_ctrl_bank (
		.clk       (clk),
		.rst       (rst),
		.a_wr      (p_wr_ctrl),
		.a_idx     (p_wr_idx),
		.a_be      (p_wr_be),
		.a_data    (p_wr_data),
		.b_wr      (c_wr_ctrl),
		.b_idx     (c_wr_idx),
		.b_be      (c_wr_be),
		.b_data    (c_wr_data),
		.a_rd_idx  (p_rd_idx),
		.b_rd_idx  (c_rd_idx),
		.a_rd_data (ctrl_bank_p_rd),
		.b_rd_data (ctrl_bank_c_rd)
	);

endmodule

`default_nettype wire

// ==== sim/shared_dmem_props.sv ====
`default_nettype none

`include "dmem_config.svh"

module shared_dmem_props (
	input logic                    clk,
	input logic                    rst,
	input logic                    p_req,
	input logic                    p_rvalid,
	input logic                    p_err,
	input logic [`DMEM_DATA_W-1:0] p_rdata,
	input logic                    c_req,
	input logic                    c_rvalid,
	input logic                    c_err,
	input logic [`DMEM_DATA_W-1:0] c_rdata
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	// A response is data or an error, never both
	a_p_excl: assert property (@(posedge clk) !(p_rvalid && p_err))
		else begin
			fail_count++;
			$error("proc port raised rvalid and err together");
		end
	a_c_excl: assert property (@(posedge clk) !(c_rvalid && c_err))
		else begin
			fail_count++;
			$error("ctrl port raised rvalid and err together");
		end

	a_p_follow: assert property (@(posedge clk) disable iff (rst)
		(p_rvalid || p_err) |-> $past(p_req))
		else begin
			fail_count++;
			$error("proc port responded without a request one cycle earlier");
		end
	a_c_follow: assert property (@(posedge clk) disable iff (rst)
		(c_rvalid || c_err) |-> $past(c_req))
		else begin
			fail_count++;
			$error("ctrl port responded without a request one cycle earlier");
		end

	a_quiet: assert property (@(posedge clk) rst |=>
		!(p_rvalid || p_err || c_rvalid || c_err) && p_rdata == '0 && c_rdata == '0)
		else begin
			fail_count++;
			$error("outputs not quiet after a reset cycle");
		end

endmodule

bind shared_dmem shared_dmem_props u_props (
	.clk      (clk),
	.rst      (rst),
	.p_req    (p_req),
	.p_rvalid (p_rvalid),
	.p_err    (p_err),
	.p_rdata  (p_rdata),
	.c_req    (c_req),
	.c_rvalid (c_rvalid),
	.c_err    (c_err),
	.c_rdata  (c_rdata)
);

`default_nettype wire

// ==== sim/shared_dmem_tb.sv ====
`default_nettype none

`include "dmem_config.svh"

module shared_dmem_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int AW = `DMEM_ADDR_W;
	localparam int DW = `DMEM_DATA_W;

	logic                      clk = 1'b0;
	logic                      rst;
	logic                      p_req, p_we, c_req, c_we;
	logic [AW-1:0]             p_addr, c_addr;
	logic [DW-1:0]             p_wdata, c_wdata, p_rdata, c_rdata;
	mem_access_pkg::load_op_t  p_load_op, c_load_op;
	mem_access_pkg::store_op_t p_store_op, c_store_op;
	logic                      p_rvalid, p_err, c_rvalid, c_err;

	// Staged request per port, index 0 is the processor
	logic          req_v [2];
	logic          we_v [2];
	logic [AW-1:0] addr_v [2];
	logic [DW-1:0] wdata_v [2];
	logic [2:0]    lop_v [2];
	logic [1:0]    sop_v [2];

	logic [DW-1:0] ref_mem [2][`DMEM_WORDS]; // Bank, then word
	string         name_q [$];
	logic [DW+1:0] p_exp_q [$]; // {err, rvalid, rdata}
	logic [DW+1:0] c_exp_q [$];
	int            checks = 0;
	int            errors = 0;
	int            timeouts = 0;

	shared_dmem u_shared_dmem (.*);

	always #2 clk = ~clk;

	function automatic logic access_ok(logic we, logic [AW-1:0] addr, logic [2:0] lop,
			logic [1:0] sop);
		logic [1:0] off;
		off = addr[1:0];
		if (we) begin
			return (sop == 2'd0 && off == 2'd0) || (sop == 2'd1 && !off[0]) || sop == 2'd2;
		end
		if (lop == 3'd0) return off == 2'd0;
		if (lop == 3'd1 || lop == 3'd2) return !off[0];
		return 1'b1; // Bytes and unused codes
	endfunction

	// Expected {err, rvalid, rdata} against the model before this cycle's stores
	function automatic logic [DW+1:0] expect_result(logic req, logic we, logic [AW-1:0] addr,
			logic [2:0] lop, logic [1:0] sop);
		logic [DW-1:0] word;
		logic [DW-1:0] shifted;
		if (!req) return '0;
		if (!access_ok(we, addr, lop, sop)) return {1'b1, 1'b0, {DW{1'b0}}};
		if (we) return '0;
		word    = ref_mem[addr[`DMEM_BANK_BIT]][addr[`DMEM_BANK_BIT-1:2]];
		shifted = word >> {addr[1:0], 3'b000}; // Addressed lane down to bit 0
		case (lop)
			3'd0:    return {2'b01, word};
			3'd1:    return {2'b01, {16{shifted[15]}}, shifted[15:0]};
			3'd2:    return {2'b01, 16'h0, shifted[15:0]};
			3'd3:    return {2'b01, {24{shifted[7]}}, shifted[7:0]};
			3'd4:    return {2'b01, 24'h0, shifted[7:0]};
			default: return {2'b01, {DW{1'b0}}};
		endcase
	endfunction

	function automatic void apply_store(logic [AW-1:0] addr, logic [DW-1:0] data,
			logic [1:0] sop);
		logic                   bank;
		mem_map_pkg::word_idx_t w;
		int                     lo;
		int                     n;
		bank = addr[`DMEM_BANK_BIT];
		w    = addr[`DMEM_BANK_BIT-1:2];
		lo   = (sop == 2'd0) ? 0 : int'(addr[1:0]);
		n    = (sop == 2'd0) ? 4 : ((sop == 2'd1) ? 2 : 1);
		for (int i = 0; i < n; i++) begin
			ref_mem[bank][w][8*(lo+i) +: 8] = data[8*i +: 8];
		end
	endfunction

	task automatic set_access(int port, logic req, logic we, logic [AW-1:0] addr,
			logic [DW-1:0] data, logic [2:0] lop, logic [1:0] sop);
		req_v[port]   = req;
		we_v[port]    = we;
		addr_v[port]  = addr;
		wdata_v[port] = data;
		lop_v[port]   = lop;
		sop_v[port]   = sop;
	endtask

	task automatic load_req(int port, logic [AW-1:0] addr, logic [2:0] lop);
		set_access(port, 1'b1, 1'b0, addr, '0, lop, 2'd0);
	endtask

	task automatic store_req(int port, logic [AW-1:0] addr, logic [DW-1:0] data,
			logic [1:0] sop);
		set_access(port, 1'b1, 1'b1, addr, data, 3'd0, sop);
	endtask

	// One cycle of requests on the falling edge
	task automatic issue_cycle(string test);
		logic [DW+1:0] p_exp;
		logic [DW+1:0] c_exp;
		@(negedge clk);
		p_req      = req_v[0];
		p_we       = we_v[0];
		p_addr     = addr_v[0];
		p_wdata    = wdata_v[0];
		p_load_op  = mem_access_pkg::load_op_t'(lop_v[0]);
		p_store_op = mem_access_pkg::store_op_t'(sop_v[0]);
		c_req      = req_v[1];
		c_we       = we_v[1];
		c_addr     = addr_v[1];
		c_wdata    = wdata_v[1];
		c_load_op  = mem_access_pkg::load_op_t'(lop_v[1]);
		c_store_op = mem_access_pkg::store_op_t'(sop_v[1]);
		p_exp = expect_result(req_v[0], we_v[0], addr_v[0], lop_v[0], sop_v[0]);
		c_exp = expect_result(req_v[1], we_v[1], addr_v[1], lop_v[1], sop_v[1]);
		for (int i = 0; i < 2; i++) begin // Controller last, so it wins shared bytes
			if (req_v[i] && we_v[i] && access_ok(1'b1, addr_v[i], 3'd0, sop_v[i])) begin
				apply_store(addr_v[i], wdata_v[i], sop_v[i]);
			end
		end
		name_q.push_back(test);
		p_exp_q.push_back(p_exp);
		c_exp_q.push_back(c_exp);
		set_access(0, 1'b0, 1'b0, '0, '0, 3'd0, 2'd0);
		set_access(1, 1'b0, 1'b0, '0, '0, 3'd0, 2'd0);
	endtask

	task automatic check_port(string test, string port, logic [DW+1:0] exp,
			logic [DW+1:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("FAILED %s %s: expected err/rvalid/rdata %b/%b/%h, actual %b/%b/%h",
				test, port, exp[DW+1], exp[DW], exp[DW-1:0], act[DW+1], act[DW], act[DW-1:0]);
		end
	endtask

	// Outputs seen here belong to the requests queued one cycle earlier
	always @(posedge clk) begin
		if (name_q.size() > 1) begin
			check_port(name_q[0], "proc", p_exp_q.pop_front(), {p_err, p_rvalid, p_rdata});
			check_port(name_q.pop_front(), "ctrl", c_exp_q.pop_front(),
				{c_err, c_rvalid, c_rdata});
		end
	end

	initial begin
		logic [AW-1:0] a;
		logic [1:0]    ln;
		void'($urandom(32'h1cd5));
		rst = 1'b1;
		p_req = 1'b0;
		p_we = 1'b0;
		p_addr = '0;
		p_wdata = '0;
		p_load_op = mem_access_pkg::LD_W;
		p_store_op = mem_access_pkg::ST_W;
		c_req = 1'b0;
		c_we = 1'b0;
		c_addr = '0;
		c_wdata = '0;
		c_load_op = mem_access_pkg::LD_W;
		c_store_op = mem_access_pkg::ST_W;
		set_access(0, 1'b0, 1'b0, '0, '0, 3'd0, 2'd0);
		set_access(1, 1'b0, 1'b0, '0, '0, 3'd0, 2'd0);
		for (int b = 0; b < 2; b++) begin
			for (int w = 0; w < `DMEM_WORDS; w++) begin
				ref_mem[b][w] = '0;
			end
		end
		for (int i = 0; i < 2; i++) begin
			@(posedge clk);
		end
		@(negedge clk);
		rst = 1'b0;

		for (int i = 0; i < 2 * `DMEM_WORDS; i++) begin
			load_req(0, AW'(4 * i), 3'd0);
			load_req(1, AW'(4 * i) ^ 7'h40, 3'd0);
			issue_cycle("reset_clear");
		end

		// Each store size at each aligned lane, then every load code at every lane
		for (int s = 0; s < 3; s++) begin
			for (int l = 0; l < 4; l++) begin
				if (access_ok(1'b1, AW'(l), 3'd0, 2'(s))) begin
					a = AW'(16 * s + 4 * l + l);
					store_req(0, a, $urandom, 2'(s));
					store_req(1, a | 7'h40, $urandom, 2'(s));
					issue_cycle("store_lanes");
					for (int op = 0; op < 8; op++) begin
						for (int k = 0; k < 4; k++) begin
							load_req(0, {a[AW-1:2], 2'(k)}, 3'(op));
							load_req(1, {a[AW-1:2], 2'(k)} | 7'h40, 3'(op));
							issue_cycle("load_ops");
						end
					end
				end
			end
		end

		for (int w = 0; w < `DMEM_WORDS; w += 3) begin
			store_req(0, AW'(64 + 4 * w), $urandom, 2'd0);
			store_req(1, AW'(4 * w), $urandom, 2'd0);
			issue_cycle("cross_store");
			load_req(0, AW'(4 * w), 3'd0);
			load_req(1, AW'(64 + 4 * w), 3'd0);
			issue_cycle("cross_load");
		end

		for (int i = 0; i < 16; i++) begin
			a  = AW'($urandom) & 7'h7c;
			ln = 2'($urandom);
			store_req(0, a, $urandom, 2'd0);
			if (i % 2 == 0) begin
				store_req(1, a | AW'(ln), $urandom, 2'd2);
			end else begin
				store_req(1, a | AW'({ln[1], 1'b0}), $urandom, 2'd1);
			end
			issue_cycle("collision");
			store_req(0, a, $urandom, 2'd0);
			load_req(1, a, 3'd0); // Sees the collision result, not this store
			issue_cycle("read_before_write");
			load_req(0, a, 3'd0);
			load_req(1, a, 3'd0);
			issue_cycle("collision_readback");
		end

		for (int l = 1; l < 4; l++) begin
			store_req(0, AW'(8 + l), $urandom, 2'd0);
			load_req(1, AW'(72 + l), 3'd0);
			issue_cycle("misaligned_word");
			store_req(0, AW'(12 + l), $urandom, (l == 2) ? 2'd3 : 2'd1);
			if (l == 2) begin
				store_req(1, AW'(76), $urandom, 2'd3);
			end else begin
				load_req(1, AW'(76 + l), (l == 1) ? 3'd1 : 3'd2);
			end
			issue_cycle("misaligned_half");
			load_req(0, AW'(8), 3'd0);
			load_req(1, AW'(12), 3'd0);
			issue_cycle("misaligned_check");
			load_req(0, AW'(72), 3'd0);
			load_req(1, AW'(76), 3'd0);
			issue_cycle("misaligned_check");
		end

		for (int i = 0; i < 400; i++) begin
			for (int port = 0; port < 2; port++) begin
				set_access(port, ($urandom % 4) != 0, 1'($urandom), AW'($urandom), $urandom,
					3'($urandom), 2'($urandom));
			end
			issue_cycle("random_mix");
		end

		issue_cycle("drain");
		for (int i = 0; i < 8 && name_q.size() > 1; i++) begin
			@(negedge clk);
		end
		if (name_q.size() > 1) begin
			timeouts++;
			$display("Timed out waiting for the last responses to be compared");
		end

		$display("Checks: %0d, errors: %0d, assertion failures: %0d, timeouts: %0d",
			checks, errors, u_shared_dmem.u_props.fail_count, timeouts);
		if (errors == 0 && timeouts == 0 && u_shared_dmem.u_props.fail_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== shared_dmem.f ====
+incdir+include
hw/mem_access_pkg.sv
hw/mem_map_pkg.sv
hw/dmem_bank.sv
hw/dmem_port.sv
hw/shared_dmem.sv
sim/shared_dmem_props.sv
sim/shared_dmem_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --assert --timescale 1ns/1ps
TOP       = shared_dmem_tb
FILELIST  = shared_dmem.f
OBJDIR    = obj_dir
SIM_BIN   = $(OBJDIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(wildcard hw/*.sv sim/*.sv include/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	! grep -q "CHECKS FAILED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
